/* hw/board_pkg.sv */
package board_pkg;

    //--------------------------------------------------------------------------
    // Board clock and port widths

    localparam int clk_mhz = 50;                  // FPGA_CLK1_50 oscillator

    localparam int w_key   = 2;                   // Onboard push buttons, active low
    localparam int w_sw    = 4;                   // Slide switches, top one is reset
    localparam int w_led   = 8;                   // Green LEDs
    localparam int w_gpio  = 36;                  // Each 40-pin header

    //--------------------------------------------------------------------------
    // INMP441 microphone on GPIO_0

    localparam int pin_mic_lr    = 0;             // JP1 pin 1, channel select
    localparam int pin_mic_gnd   = 1;             // JP1 pin 2, supply return
    localparam int pin_mic_ws    = 2;             // JP1 pin 3
    localparam int pin_mic_vcc   = 3;             // JP1 pin 4, powered from the FPGA
    localparam int pin_mic_sck   = 4;             // JP1 pin 5
    localparam int pin_mic_sd    = 5;             // JP1 pin 6, serial data in

    //--------------------------------------------------------------------------
    // I2S DAC on GPIO_0

    localparam int pin_dac_mclk  = 17;            // JP1 pin 20
    localparam int pin_dac_bclk  = 15;            // JP1 pin 18
    localparam int pin_dac_lrclk = 11;            // JP1 pin 14
    localparam int pin_dac_sdata = 13;            // JP1 pin 16

    //--------------------------------------------------------------------------
    // MiSTer I/O add-on

    localparam int pin_btn_reset = 14;            // GPIO_1, JP7 pin 17, weak pull-up

    // Level meter: LED [0] lights once bit 8 of the magnitude is set
    localparam int led_meter_floor = 7;

endpackage

/* hw/audio_pkg.sv */
package audio_pkg;

    //--------------------------------------------------------------------------
    // Sample formats

    localparam int mic_w = 24;                    // INMP441 word
    localparam int dac_w = 16;                    // DAC word, upper part of mic word

    typedef logic signed [mic_w - 1:0] mic_sample_t;
    typedef logic signed [dac_w - 1:0] dac_sample_t;

    //--------------------------------------------------------------------------
    // I2S frame timing, shared by receiver and transmitter

    localparam int sclk_half  = 8;                // clk cycles per sck or bclk half period
    localparam int slot_bits  = 32;               // Serial clocks per channel slot
    localparam int frame_clks = 2 * slot_bits * 2 * sclk_half;   // 1024 clk per frame

    localparam int half_cnt_w = $clog2 (sclk_half);
    localparam int bit_cnt_w  = $clog2 (2 * slot_bits);          // MSB selects the slot
    localparam int slot_pos_w = bit_cnt_w - 1;

    //--------------------------------------------------------------------------
    // Sample FIFO

    localparam int fifo_depth = 8;
    localparam int fifo_ptr_w = $clog2 (fifo_depth);
    localparam int fifo_cnt_w = $clog2 (fifo_depth + 1);

    typedef struct packed
    {
        logic empty;                              // No entry, pop_data not valid
        logic full;                               // Next push is dropped
        logic overflow;                           // Sticky, a push was dropped
    } fifo_status_t;

endpackage

/* hw/mic_i2s_receiver.sv */
`timescale 1ns/100ps

module mic_i2s_receiver
(
    input  logic                   clk,
    input  logic                   rst,

    output logic                   sck,        // To INMP441
    output logic                   ws,         // Low in the left slot
    output logic                   lr,         // Channel select of the mic
    input  logic                   sd,

    output logic                   push,       // One clk pulse per frame
    output audio_pkg::mic_sample_t push_data
);

    import audio_pkg::*;
    import board_pkg::*;

    // INMP441 accepts sck from 0.5 to 3.3 MHz
    if (clk_mhz * 1000 / (2 * sclk_half) < 500
        || clk_mhz * 1000 / (2 * sclk_half) > 3300)
    begin : g_sck_range
        $error ("mic_i2s_receiver: sck rate outside INMP441 range");
    end

    //--------------------------------------------------------------------------

    logic [half_cnt_w - 1:0] half_cnt;         // clk cycles within sck half period
    logic [bit_cnt_w  - 1:0] bit_cnt;          // sck periods within the frame
    logic [slot_pos_w - 1:0] slot_pos;

    logic                    half_end;
    logic                    sck_rise;
    logic                    sck_fall;
    logic                    capture;

    mic_sample_t             shift;

    assign half_end = (half_cnt == half_cnt_w' (sclk_half - 1));
    assign sck_rise = half_end & ~ sck;        // sck goes high at the next edge
    assign sck_fall = half_end &   sck;

    assign slot_pos = bit_cnt [slot_pos_w - 1:0];
    assign ws       = bit_cnt [bit_cnt_w - 1];  // Changes only after an sck fall
    assign lr       = 1'b0;                     // Mic answers in the left slot

    // Slot bit 0 is the I2S delay bit, data bits follow MSB first
    assign capture  = sck_rise & ~ ws
                    & (slot_pos != '0)
                    & (slot_pos <= slot_pos_w' (mic_w));

    //--------------------------------------------------------------------------
    // Serial clock and frame position

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            half_cnt <= '0;
            sck      <= 1'b0;
            bit_cnt  <= '0;
        end
        else
        begin
            if (half_end)
            begin
                half_cnt <= '0;
                sck      <= ~ sck;
            end
            else
            begin
                half_cnt <= half_cnt + 1'b1;
            end

            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;     // Wraps at the frame end
        end
    end

    //--------------------------------------------------------------------------
    // Data capture

    always_ff @ (posedge clk)
    begin
        if (capture)
            shift <= { shift [mic_w - 2:0], sd };
    end

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
            push <= 1'b0;
        else
            push <= sck_rise & ~ ws & (slot_pos == slot_pos_w' (mic_w));  // Last data bit
    end

    assign push_data = shift;                  // Holds until the next left slot

endmodule

/* hw/sample_fifo.sv */
`timescale 1ns/100ps

module sample_fifo
(
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     push,
    input  audio_pkg::mic_sample_t   push_data,

    input  logic                     pop,
    output audio_pkg::mic_sample_t   pop_data,

    output audio_pkg::fifo_status_t  status
);

    import audio_pkg::*;

    //--------------------------------------------------------------------------

    mic_sample_t             mem [fifo_depth];

    logic [fifo_ptr_w - 1:0] wr_ptr;
    logic [fifo_ptr_w - 1:0] rd_ptr;
    logic [fifo_cnt_w - 1:0] count;            // Entries held, 0 to fifo_depth
    logic                    overflow;

    logic                    do_push;
    logic                    do_pop;

    assign status.empty    = (count == '0);
    assign status.full     = (count == fifo_cnt_w' (fifo_depth));
    assign status.overflow = overflow;

    assign do_push  = push & ~ status.full;    // Full drops the sample
    assign do_pop   = pop  & ~ status.empty;

    assign pop_data = mem [rd_ptr];            // Head entry, valid while not empty

    //--------------------------------------------------------------------------
    // Storage

    always_ff @ (posedge clk)
    begin
        if (do_push)
            mem [wr_ptr] <= push_data;
    end

    //--------------------------------------------------------------------------
    // Pointers, count and sticky overflow

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;       // Depth is a power of two

            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;

            case ({ do_push, do_pop })
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Both or neither
            endcase

            if (push & status.full)
                overflow <= 1'b1;              // Held until reset
        end
    end

endmodule

/* hw/i2s_audio_out.sv */
`timescale 1ns/100ps

module i2s_audio_out
(
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     mute,       // Zeros in both slots
    output logic                     pop,
    input  audio_pkg::mic_sample_t   pop_data,
    input  audio_pkg::fifo_status_t  status,

    output logic                     mclk,
    output logic                     bclk,
    output logic                     lrclk,      // Low in the left slot
    output logic                     sdata,

    output audio_pkg::dac_sample_t   last_sample
);

    import audio_pkg::*;
    import board_pkg::*;

    // Frame rate must stay within the usual DAC range of 8 to 96 kHz
    if (clk_mhz * 1000000 / frame_clks < 8000
        || clk_mhz * 1000000 / frame_clks > 96000)
    begin : g_fs_range
        $error ("i2s_audio_out: frame rate outside DAC range");
    end

    //--------------------------------------------------------------------------

    logic [half_cnt_w - 1:0] half_cnt;
    logic [bit_cnt_w  - 1:0] bit_cnt;           // bclk periods within the frame
    logic [bit_cnt_w  - 1:0] next_bit;
    logic [slot_pos_w - 1:0] next_pos;

    logic                    half_end;
    logic                    bclk_fall;
    logic                    start_q;           // First clk of a frame

    dac_sample_t             load_val;
    dac_sample_t             sample_q;          // Word sent in the current frame
    dac_sample_t             shift;

    assign half_end  = (half_cnt == half_cnt_w' (sclk_half - 1));
    assign bclk_fall = half_end & bclk;
    assign next_bit  = bit_cnt + 1'b1;
    assign next_pos  = next_bit [slot_pos_w - 1:0];
    assign lrclk     = bit_cnt [bit_cnt_w - 1];

    // Pop only when an entry is there, otherwise this frame is silent
    assign pop       = start_q & ~ status.empty;
    assign load_val  = (pop & ~ mute) ? pop_data [mic_w - 1 -: dac_w] : '0;

    assign last_sample = sample_q;

    //--------------------------------------------------------------------------
    // Clock dividers

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mclk     <= 1'b0;
            half_cnt <= '0;
            bclk     <= 1'b0;
            bit_cnt  <= '0;
            start_q  <= 1'b0;
        end
        else
        begin
            mclk <= ~ mclk;                     // clk / 2

            if (half_end)
            begin
                half_cnt <= '0;
                bclk     <= ~ bclk;
            end
            else
            begin
                half_cnt <= half_cnt + 1'b1;
            end

            if (bclk_fall)
                bit_cnt <= next_bit;

            start_q <= bclk_fall & (bit_cnt == '1);   // lrclk falls here
        end
    end

    //--------------------------------------------------------------------------
    // Serializer, MSB one bclk after the slot edge

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sample_q <= '0;
            shift    <= '0;
            sdata    <= 1'b0;
        end
        else if (start_q)
        begin
            sample_q <= load_val;
            shift    <= load_val;               // Left slot word
        end
        else if (bclk_fall)
        begin
            if (next_pos == '0)
            begin
                sdata <= 1'b0;                  // Delay bit
                shift <= sample_q;              // Right slot repeats the word
            end
            else if (next_pos <= slot_pos_w' (dac_w))
            begin
                sdata <= shift [dac_w - 1];
                shift <= shift << 1;
            end
            else
            begin
                sdata <= 1'b0;                  // Slot padding
            end
        end
    end

endmodule

/* hw/board_specific_top.sv */
`timescale 1ns/100ps

module board_specific_top
(
    input                               FPGA_CLK1_50,

    input  [board_pkg::w_key  - 1:0]    KEY,
    input  [board_pkg::w_sw   - 1:0]    SW,
    output [board_pkg::w_led  - 1:0]    LED,

    inout  [board_pkg::w_gpio - 1:0]    GPIO_0,
    inout  [board_pkg::w_gpio - 1:0]    GPIO_1
);

    import board_pkg::*;
    import audio_pkg::*;

    typedef struct packed
    {
        logic mic_sck;
        logic mic_ws;
        logic mic_lr;
        logic dac_mclk;
        logic dac_bclk;
        logic dac_lrclk;
        logic dac_sdata;
    } i2s_pins_t;

    //--------------------------------------------------------------------------

    logic                clk;
    logic                rst;
    logic [1:0]          mute_sync;             // KEY [0] into the clk domain

    logic                mic_sck, mic_ws, mic_lr;
    logic                dac_mclk, dac_bclk, dac_lrclk, dac_sdata;
    i2s_pins_t           pins_d, pins_q;

    logic                push, pop;
    mic_sample_t         push_data, pop_data;
    fifo_status_t        fifo_status;           // Overflow stays internal
    dac_sample_t         last_sample;

    logic signed [dac_w:0] wide;                // One extra bit for -32768
    logic [dac_w - 1:0]  mag;                   // At most 32768
    logic [3:0]          lit;                   // LEDs to light, 0 to w_led
    logic [w_led - 1:0]  led_d, led_q;

    assign clk = FPGA_CLK1_50;
    assign rst = SW [w_sw - 1] | ~ GPIO_1 [pin_btn_reset];   // Switch or add-on button

    //--------------------------------------------------------------------------
    // Audio path

    mic_i2s_receiver i_microphone
    (
        .clk       ( clk                   ),
        .rst       ( rst                   ),
        .sck       ( mic_sck               ),
        .ws        ( mic_ws                ),
        .lr        ( mic_lr                ),
        .sd        ( GPIO_0 [pin_mic_sd]   ),
        .push      ( push                  ),
        .push_data ( push_data             )
    );

    sample_fifo i_sample_fifo
    (
        .clk       ( clk                   ),
        .rst       ( rst                   ),
        .push      ( push                  ),
        .push_data ( push_data             ),
        .pop       ( pop                   ),
        .pop_data  ( pop_data              ),
        .status    ( fifo_status           )
    );

    i2s_audio_out i_audio_out
    (
        .clk         ( clk                 ),
        .rst         ( rst                 ),
        .mute        ( mute_sync [1]       ),
        .pop         ( pop                 ),
        .pop_data    ( pop_data            ),
        .status      ( fifo_status         ),
        .mclk        ( dac_mclk            ),
        .bclk        ( dac_bclk            ),
        .lrclk       ( dac_lrclk           ),
        .sdata       ( dac_sdata           ),
        .last_sample ( last_sample         )
    );

    //--------------------------------------------------------------------------
    // Level meter, thermometer of the highest set magnitude bit

    always_comb
    begin
        wide = last_sample;                     // Sign extended
        mag  = dac_w' (wide [dac_w] ? - wide : wide);
        lit  = '0;

        for (int i = led_meter_floor + 1; i < dac_w; i++)
            if (mag [i])
                lit = 4' (i - led_meter_floor);

        led_d = ~ ({ w_led { 1'b1 } } << lit);  // Shift by w_led lights all
    end

    always_comb
    begin
        pins_d.mic_sck   = mic_sck;
        pins_d.mic_ws    = mic_ws;
        pins_d.mic_lr    = mic_lr;
        pins_d.dac_mclk  = dac_mclk;
        pins_d.dac_bclk  = dac_bclk;
        pins_d.dac_lrclk = dac_lrclk;
        pins_d.dac_sdata = dac_sdata;
    end

    //--------------------------------------------------------------------------
    // Output registers and mute synchronizer

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mute_sync <= '0;
            pins_q    <= '0;
            led_q     <= '0;
        end
        else
        begin
            mute_sync <= { mute_sync [0], ~ KEY [0] };   // Pressed means mute
            pins_q    <= pins_d;
            led_q     <= led_d;
        end
    end

    assign LED = led_q;

    assign GPIO_0 [pin_mic_lr   ]  = pins_q.mic_lr;
    assign GPIO_0 [pin_mic_ws   ]  = pins_q.mic_ws;
    assign GPIO_0 [pin_mic_sck  ]  = pins_q.mic_sck;
    assign GPIO_0 [pin_mic_gnd  ]  = 1'b0;
    assign GPIO_0 [pin_mic_vcc  ]  = 1'b1;

    assign GPIO_0 [pin_dac_mclk ]  = pins_q.dac_mclk;
    assign GPIO_0 [pin_dac_bclk ]  = pins_q.dac_bclk;
    assign GPIO_0 [pin_dac_lrclk]  = pins_q.dac_lrclk;
    assign GPIO_0 [pin_dac_sdata]  = pins_q.dac_sdata;

endmodule

/* test/tb_i2s_models.sv */
`timescale 1ns/100ps

//--------------------------------------------------------------------------
// INMP441 model, one 24-bit word in the left slot of every frame

module tb_mic_model
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   sck,
    input  logic                   ws,
    output logic                   sd,
    input  audio_pkg::mic_sample_t word,        // Table row to send next
    output logic                   sent         // Pulse with the last data bit
);

    import audio_pkg::*;

    logic        sck_q;
    logic        ws_q;                          // ws at the previous sck fall
    logic [5:0]  pos;                           // Slot bit of the coming sck period
    mic_sample_t cur;

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sck_q <= 1'b0;
            ws_q  <= 1'b0;                      // Delay bit runs during reset release
            pos   <= 6'd1;
            cur   <= word;
            sd    <= 1'b0;
            sent  <= 1'b0;
        end
        else
        begin
            sck_q <= sck;
            sent  <= 1'b0;

            if (sck_q & ~ sck)                  // sck fall, mic drives next bit
            begin
                ws_q <= ws;

                if (ws)
                    sd <= 1'b0;                 // Right slot left floating on a real mic
                else if (ws_q)
                begin
                    sd  <= 1'b0;                // Delay bit of the new frame
                    pos <= 6'd1;
                    cur <= word;
                end
                else
                begin
                    pos  <= pos + 1'b1;
                    sd   <= (pos <= mic_w) ? cur [mic_w - pos] : 1'b0;
                    sent <= (pos == mic_w);
                end
            end
        end
    end

endmodule

//--------------------------------------------------------------------------
// DAC side, collects the first 16 bits of each slot

module tb_dac_capture
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   bclk,
    input  logic                   lrclk,
    input  logic                   sdata,
    output audio_pkg::dac_sample_t left,
    output audio_pkg::dac_sample_t right,
    output logic                   done         // Both slots of a frame in
);

    import audio_pkg::*;

    logic        bclk_q;
    logic        lr_q;
    logic [5:0]  pos;
    logic [5:0]  pos_now;                       // Slot bit at this bclk rise
    dac_sample_t shift;
    dac_sample_t word;

    assign pos_now = (lrclk != lr_q) ? 6'd0 : pos + 1'b1;
    assign word    = { shift [dac_w - 2:0], sdata };

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bclk_q <= 1'b0;
            lr_q   <= 1'b1;                     // Frame 0 starts without an lrclk fall
            pos    <= '0;
            shift  <= '0;
            left   <= '0;
            right  <= '0;
            done   <= 1'b0;
        end
        else
        begin
            bclk_q <= bclk;
            done   <= 1'b0;

            if (~ bclk_q & bclk)                // Data stable at the rising bclk
            begin
                lr_q <= lrclk;
                pos  <= pos_now;

                if (pos_now != 0 && pos_now <= dac_w)
                    shift <= word;

                if (pos_now == dac_w)
                begin
                    if (lrclk)
                    begin
                        right <= word;
                        done  <= 1'b1;
                    end
                    else
                        left <= word;
                end
            end
        end
    end

endmodule

/* test/tb_board_top.sv */
`timescale 1ns/100ps

module tb_board_top;

    import board_pkg::*;
    import audio_pkg::*;

    localparam int n_rows     = 16;
    localparam int reset_clks = 16;
    localparam int limit      = (n_rows + 8) * frame_clks;   // Whole sequence plus margin

    logic                clk;
    logic [w_sw - 1:0]   sw;
    logic [w_key - 1:0]  key;
    logic                btn_n;                 // Add-on reset button, low pressed
    logic [w_led - 1:0]  led;
    wire  [w_gpio - 1:0] gpio_0;
    wire  [w_gpio - 1:0] gpio_1;

    logic                model_rst;
    logic                mic_sd;
    logic                mic_sent;
    mic_sample_t         mic_word;
    dac_sample_t         cap_left;
    dac_sample_t         cap_right;
    logic                cap_done;
    logic                mclk_div;              // clk / 2
    logic                mclk_ref;              // Expected mclk at the pin

    mic_sample_t         tab_sample [n_rows];   // Stimulus
    dac_sample_t         tab_dac    [n_rows];   // Expected DAC word
    logic [w_led - 1:0]  tab_led    [n_rows];   // Expected meter

    int                  mic_row  = 0;          // Row the mic model sends
    int                  pending [$];           // Rows sent, not yet heard at the DAC
    bit                  synced;
    int                  cycles   = 0;

    //--------------------------------------------------------------------------
    // DUT, models and clock

    board_specific_top dut_i
    (
        .FPGA_CLK1_50 ( clk    ),
        .KEY          ( key    ),
        .SW           ( sw     ),
        .LED          ( led    ),
        .GPIO_0       ( gpio_0 ),
        .GPIO_1       ( gpio_1 )
    );

    tb_mic_model mic_i
    (
        .clk  ( clk                  ),
        .rst  ( model_rst            ),
        .sck  ( gpio_0 [pin_mic_sck] ),
        .ws   ( gpio_0 [pin_mic_ws]  ),
        .sd   ( mic_sd               ),
        .word ( mic_word             ),
        .sent ( mic_sent             )
    );

    tb_dac_capture dac_i
    (
        .clk   ( clk                    ),
        .rst   ( model_rst              ),
        .bclk  ( gpio_0 [pin_dac_bclk]  ),
        .lrclk ( gpio_0 [pin_dac_lrclk] ),
        .sdata ( gpio_0 [pin_dac_sdata] ),
        .left  ( cap_left               ),
        .right ( cap_right              ),
        .done  ( cap_done               )
    );

    assign gpio_0 [pin_mic_sd]    = mic_sd;
    assign gpio_1 [pin_btn_reset] = btn_n;
    assign model_rst = sw [w_sw - 1] | ~ btn_n;  // Same reset as the board
    assign mic_word  = tab_sample [mic_row];

    always #5 clk = ~ clk;

    always @ (negedge clk)
    begin
        if (mic_sent)
        begin
            pending.push_back (mic_row);
            mic_row = (mic_row + 1) % n_rows;
        end
    end

    // mclk runs at clk / 2 from reset and passes one output register
    always @ (posedge clk or posedge model_rst)
    begin
        if (model_rst)
        begin
            mclk_div <= 1'b0;
            mclk_ref <= 1'b0;
        end
        else
        begin
            mclk_div <= ~ mclk_div;
            mclk_ref <= mclk_div;
        end
    end

    always @ (posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= limit)
        begin
            $display ("Timeout: sequence not finished after %0d cycles", cycles);
            abort_run ();
        end
    end

    //--------------------------------------------------------------------------
    // Expected values and checks

    function automatic logic [w_led - 1:0] led_level (input dac_sample_t s);
        int mag;
        int lit;
        mag = (s < 0) ? - int' (s) : int' (s);
        lit = 0;
        while ((mag >> (led_meter_floor + lit + 1)) != 0 && lit < w_led)
            lit++;
        return w_led' ((1 << lit) - 1);           // Filled from LED [0]
    endfunction

    task automatic abort_run ();
        $display ("Testbench failed");
        $fatal (1, "Run stopped at the first error");
    endtask

    task automatic check_pin (input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display ("MISMATCH %s: expected %b, actual %b", name, exp, act);
            abort_run ();
        end
    endtask

    task automatic check_dac (input string name, input dac_sample_t exp,
                              input dac_sample_t act);
        if (act !== exp)
        begin
            $display ("MISMATCH %s: expected %h, actual %h", name, exp, act);
            abort_run ();
        end
    endtask

    task automatic check_led (input string name, input logic [w_led - 1:0] exp,
                              input logic [w_led - 1:0] act);
        if (act !== exp)
        begin
            $display ("MISMATCH %s: expected %b, actual %b", name, exp, act);
            abort_run ();
        end
    endtask

    task automatic check_idle (input string name);
        check_pin ({ name, " sck"   }, 1'b0, gpio_0 [pin_mic_sck]);
        check_pin ({ name, " ws"    }, 1'b0, gpio_0 [pin_mic_ws]);
        check_pin ({ name, " bclk"  }, 1'b0, gpio_0 [pin_dac_bclk]);
        check_pin ({ name, " lrclk" }, 1'b0, gpio_0 [pin_dac_lrclk]);
        check_pin ({ name, " sdata" }, 1'b0, gpio_0 [pin_dac_sdata]);
        check_pin ({ name, " gnd"   }, 1'b0, gpio_0 [pin_mic_gnd]);
        check_pin ({ name, " vcc"   }, 1'b1, gpio_0 [pin_mic_vcc]);
        check_led ({ name, " led"   }, '0,   led);
    endtask

    task automatic wait_frame ();
        do
            @ (posedge clk);
        while (! cap_done);
    endtask

    // One captured frame, data tells whether a table row came out
    task automatic check_frame (input string name, output bit data);
        int r;
        data = 1'b0;
        check_pin ({ name, " lr"   }, 1'b0,     gpio_0 [pin_mic_lr]);
        check_pin ({ name, " mclk" }, mclk_ref, gpio_0 [pin_dac_mclk]);
        if (! key [0])
        begin
            if (pending.size () == 0)
            begin
                $display ("%s: no sample waiting while muted", name);
                abort_run ();
            end
            r = pending.pop_front ();           // Muted sample is still consumed
            check_dac ({ name, " left"  }, '0, cap_left);
            check_dac ({ name, " right" }, '0, cap_right);
            check_led ({ name, " led"   }, '0, led);
        end
        else if (! synced && cap_left == '0 && cap_right == '0)
            check_led ({ name, " led" }, '0, led);   // Silent before the first sample
        else
        begin
            if (pending.size () == 0)
            begin
                $display ("%s: DAC sent data that the mic never produced", name);
                abort_run ();
            end
            r      = pending.pop_front ();
            synced = 1'b1;
            data   = 1'b1;
            check_dac ({ name, " left"  }, tab_dac [r], cap_left);
            check_dac ({ name, " right" }, tab_dac [r], cap_right);
            check_led ({ name, " led"   }, tab_led [r], led);
        end
    endtask

    //--------------------------------------------------------------------------
    // Sequence

    initial
    begin
        bit data;
        int n;

        clk   = 1'b0;
        sw    = '0;
        sw [w_sw - 1] = 1'b1;
        key   = '1;
        btn_n = 1'b1;
        synced = 1'b0;
        void' ($urandom (58461));

        tab_sample [0] = 24'h7fffff;            // Full scale positive
        tab_sample [1] = 24'h800000;            // Full scale negative
        tab_sample [2] = 24'h000100;            // Smallest nonzero DAC word
        tab_sample [3] = 24'hffffff;
        tab_sample [4] = 24'h0080ab;            // Just under the first LED
        tab_sample [5] = 24'h010000;            // First LED
        tab_sample [6] = 24'hff7f00;
        tab_sample [7] = 24'hc00000;
        for (int i = 8; i < n_rows; i++)
        begin
            tab_sample [i] = mic_sample_t' ($urandom);
            if (tab_sample [i][mic_w - 1 -: dac_w] == '0)
                tab_sample [i][8] = 1'b1;       // DAC word must differ from silence
        end
        for (int i = 0; i < n_rows; i++)
        begin
            tab_dac [i] = tab_sample [i][mic_w - 1 -: dac_w];
            tab_led [i] = led_level (tab_dac [i]);
        end

        repeat (reset_clks / 2) @ (posedge clk);
        check_idle ("during reset");
        repeat (reset_clks / 2) @ (posedge clk);
        sw [w_sw - 1] <= 1'b0;
        repeat (sclk_half + 1) @ (posedge clk); // Clocks still low at the pins
        check_idle ("after reset");

        n = 0;
        while (n < n_rows)
        begin
            wait_frame ();
            check_frame ("loopback", data);
            if (data)
                n++;
        end

        key [0] <= 1'b0;                        // Mute the next three frames
        repeat (3)
        begin
            wait_frame ();
            check_frame ("mute", data);
        end
        key [0] <= 1'b1;
        wait_frame ();
        check_frame ("after mute", data);

        btn_n <= 1'b0;                          // Mid-stream button reset
        repeat (reset_clks / 2) @ (posedge clk);
        check_idle ("button reset");
        pending.delete ();
        synced = 1'b0;
        repeat (reset_clks / 2) @ (posedge clk);
        btn_n <= 1'b1;
        repeat (sclk_half + 1) @ (posedge clk);
        check_idle ("after button");

        n = 0;
        while (n < 2)
        begin
            wait_frame ();
            check_frame ("button resume", data);
            if (data)
                n++;
        end

        $display ("Testbench passed");
        $finish;
    end

endmodule

/* tb.f */
hw/board_pkg.sv
hw/audio_pkg.sv
hw/mic_i2s_receiver.sv
hw/sample_fifo.sv
hw/i2s_audio_out.sv
hw/board_specific_top.sv
test/tb_i2s_models.sv
test/tb_board_top.sv

/* Bender.yml */
package:
  name: board_audio_loopback

sources:
  # Packages first, then blocks, then the board top
  - hw/board_pkg.sv
  - hw/audio_pkg.sv
  - hw/mic_i2s_receiver.sv
  - hw/sample_fifo.sv
  - hw/i2s_audio_out.sv
  - hw/board_specific_top.sv

  - target: test
    files:
      - test/tb_i2s_models.sv
      - test/tb_board_top.sv
